/* design/xfcp_down_router.sv */
`include "xfcp_defs.svh"

module xfcp_down_router (
    input  logic          clk,
    input  logic          rst,
    xfcp_stream_if.snk    up_in,
    xfcp_stream_if.src    down_out [`XFCP_DOWN_PORTS]
);

    xfcp_pkg::down_state_t state_reg;
    xfcp_pkg::down_state_t state_next;
    xfcp_pkg::port_sel_t   sel_reg;
    xfcp_pkg::port_sel_t   sel_next;

    logic                  in_ready;
    logic                  handshake;
    logic                  header_in_range;

    // per-port status of the output buffers
    xfcp_pkg::port_mask_t  buf_ready;
    xfcp_pkg::port_mask_t  buf_busy;

    xfcp_stream_if buf_in [`XFCP_DOWN_PORTS] ();

    for (genvar i = 0; i < `XFCP_DOWN_PORTS; i++) begin : g_port
        assign buf_in[i].tdata  = up_in.tdata;
        assign buf_in[i].tlast  = up_in.tlast;
        assign buf_in[i].tuser  = up_in.tuser;
        assign buf_in[i].tvalid = up_in.tvalid && state_reg == xfcp_pkg::DOWN_TRANSFER
                                  && sel_reg == xfcp_pkg::port_sel_t'(i);

        assign buf_ready[i] = buf_in[i].tready;
        assign buf_busy[i]  = down_out[i].tvalid;

        xfcp_skid_buf u_skid (
            .clk   (clk),
            .rst   (rst),
            .in_s  (buf_in[i]),
            .out_s (down_out[i])
        );
    end

    assign up_in.tready    = in_ready;
    assign handshake       = up_in.tvalid && in_ready;
    assign header_in_range = up_in.tdata < xfcp_pkg::xfcp_byte_t'(`XFCP_DOWN_PORTS);

    always_comb begin
        state_next = state_reg;
        sel_next   = sel_reg;
        in_ready   = 1'b0;

        case (state_reg)
            xfcp_pkg::DOWN_IDLE: begin
                // hold off the header until the last port has drained
                in_ready = buf_ready[sel_reg] && !buf_busy[sel_reg];
                if (handshake && !up_in.tlast) begin
                    if (header_in_range) begin
                        sel_next   = up_in.tdata[`XFCP_SEL_W-1:0];
                        state_next = xfcp_pkg::DOWN_TRANSFER;
                    end else begin
                        state_next = xfcp_pkg::DOWN_DROP;
                    end
                end
            end
            xfcp_pkg::DOWN_TRANSFER: begin
                in_ready = buf_ready[sel_reg];
                if (handshake && up_in.tlast) begin
                    state_next = xfcp_pkg::DOWN_IDLE;
                end
            end
            xfcp_pkg::DOWN_DROP: begin
                // swallow the rest of the packet
                in_ready = 1'b1;
                if (handshake && up_in.tlast) begin
                    state_next = xfcp_pkg::DOWN_IDLE;
                end
            end
            default: begin
                state_next = xfcp_pkg::DOWN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= xfcp_pkg::DOWN_IDLE;
            sel_reg   <= '0;
        end else begin
            state_reg <= state_next;
            sel_reg   <= sel_next;
        end
    end

endmodule

/* design/xfcp_pkg.sv */
`include "xfcp_defs.svh"

package xfcp_pkg;

    typedef logic [`XFCP_DATA_W-1:0] xfcp_byte_t;

    typedef logic [`XFCP_SEL_W-1:0] port_sel_t;

    // one bit per downstream port
    typedef logic [`XFCP_DOWN_PORTS-1:0] port_mask_t;

    typedef enum logic [1:0] {
        DOWN_IDLE,
        DOWN_TRANSFER,
        DOWN_DROP
    } down_state_t;

    typedef enum logic [1:0] {
        UP_IDLE,
        UP_HEADER,
        UP_TRANSFER
    } up_state_t;

endpackage

/* design/xfcp_rr_arbiter.sv */
`include "xfcp_defs.svh"

module xfcp_rr_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  xfcp_pkg::port_mask_t request,
    input  logic                 done,
    output xfcp_pkg::port_mask_t grant,
    output logic                 grant_valid,
    output xfcp_pkg::port_sel_t  grant_idx
);

    xfcp_pkg::port_sel_t  ptr_reg;
    xfcp_pkg::port_sel_t  cand;
    xfcp_pkg::port_sel_t  pick_idx;
    logic                 pick_found;

    // search from the pointer upward, wrapping, nearest requester wins
    always_comb begin
        pick_idx   = ptr_reg;
        pick_found = 1'b0;
        cand       = ptr_reg;
        for (int k = `XFCP_DOWN_PORTS - 1; k >= 0; k--) begin
            cand = ptr_reg + xfcp_pkg::port_sel_t'(k);
            if (request[cand]) begin
                pick_idx   = cand;
                pick_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_idx   <= '0;
            ptr_reg     <= '0;
        end else if (grant_valid) begin
            if (done) begin
                grant       <= '0;
                grant_valid <= 1'b0;
                ptr_reg     <= grant_idx + xfcp_pkg::port_sel_t'(1);
            end
        end else if (pick_found) begin
            grant       <= xfcp_pkg::port_mask_t'(1) << pick_idx;
            grant_valid <= 1'b1;
            grant_idx   <= pick_idx;
        end
    end

endmodule

/* design/xfcp_skid_buf.sv */
module xfcp_skid_buf (
    input  logic          clk,
    input  logic          rst,
    xfcp_stream_if.snk    in_s,
    xfcp_stream_if.src    out_s
);

    logic                 ready_reg;
    logic                 ready_early;

    logic                 out_valid_reg;
    logic                 out_valid_next;
    xfcp_pkg::xfcp_byte_t out_data_reg;
    logic                 out_last_reg;
    logic                 out_user_reg;

    logic                 temp_valid_reg;
    logic                 temp_valid_next;
    xfcp_pkg::xfcp_byte_t temp_data_reg;
    logic                 temp_last_reg;
    logic                 temp_user_reg;

    logic                 load_out_from_in;
    logic                 load_temp_from_in;
    logic                 load_out_from_temp;

    assign in_s.tready  = ready_reg;
    assign out_s.tdata  = out_data_reg;
    assign out_s.tvalid = out_valid_reg;
    assign out_s.tlast  = out_last_reg;
    assign out_s.tuser  = out_user_reg;

    // stay ready unless the temp slot could fill on the next edge
    assign ready_early = out_s.tready | (~temp_valid_reg & (~out_valid_reg | ~in_s.tvalid));

    always_comb begin
        out_valid_next     = out_valid_reg;
        temp_valid_next    = temp_valid_reg;
        load_out_from_in   = 1'b0;
        load_temp_from_in  = 1'b0;
        load_out_from_temp = 1'b0;

        if (ready_reg) begin
            if (out_s.tready || !out_valid_reg) begin
                out_valid_next   = in_s.tvalid;
                load_out_from_in = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next   = in_s.tvalid;
                load_temp_from_in = 1'b1;
            end
        end else if (out_s.tready) begin
            // input closed, drain the parked beat
            out_valid_next     = temp_valid_reg;
            temp_valid_next    = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg      <= 1'b0;
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
        end else begin
            ready_reg      <= ready_early;
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_data_reg <= in_s.tdata;
            out_last_reg <= in_s.tlast;
            out_user_reg <= in_s.tuser;
        end else if (load_out_from_temp) begin
            out_data_reg <= temp_data_reg;
            out_last_reg <= temp_last_reg;
            out_user_reg <= temp_user_reg;
        end

        if (load_temp_from_in) begin
            temp_data_reg <= in_s.tdata;
            temp_last_reg <= in_s.tlast;
            temp_user_reg <= in_s.tuser;
        end
    end

endmodule

/* design/xfcp_stream_if.sv */
interface xfcp_stream_if;

    xfcp_pkg::xfcp_byte_t tdata;
    logic                 tvalid;
    logic                 tready;
    logic                 tlast;
    logic                 tuser;

    modport src (
        output tdata,
        output tvalid,
        input  tready,
        output tlast,
        output tuser
    );

    modport snk (
        input  tdata,
        input  tvalid,
        output tready,
        input  tlast,
        input  tuser
    );

endinterface

/* design/xfcp_switch.sv */
`include "xfcp_defs.svh"

module xfcp_switch (
    input  logic                 clk,
    input  logic                 rst,

    // upstream port
    input  xfcp_pkg::xfcp_byte_t up_in_tdata,
    input  logic                 up_in_tvalid,
    output logic                 up_in_tready,
    input  logic                 up_in_tlast,
    input  logic                 up_in_tuser,
    output xfcp_pkg::xfcp_byte_t up_out_tdata,
    output logic                 up_out_tvalid,
    input  logic                 up_out_tready,
    output logic                 up_out_tlast,
    output logic                 up_out_tuser,

    // downstream ports
    input  xfcp_pkg::xfcp_byte_t down_0_in_tdata,
    input  logic                 down_0_in_tvalid,
    output logic                 down_0_in_tready,
    input  logic                 down_0_in_tlast,
    input  logic                 down_0_in_tuser,
    output xfcp_pkg::xfcp_byte_t down_0_out_tdata,
    output logic                 down_0_out_tvalid,
    input  logic                 down_0_out_tready,
    output logic                 down_0_out_tlast,
    output logic                 down_0_out_tuser,

    input  xfcp_pkg::xfcp_byte_t down_1_in_tdata,
    input  logic                 down_1_in_tvalid,
    output logic                 down_1_in_tready,
    input  logic                 down_1_in_tlast,
    input  logic                 down_1_in_tuser,
    output xfcp_pkg::xfcp_byte_t down_1_out_tdata,
    output logic                 down_1_out_tvalid,
    input  logic                 down_1_out_tready,
    output logic                 down_1_out_tlast,
    output logic                 down_1_out_tuser,

    input  xfcp_pkg::xfcp_byte_t down_2_in_tdata,
    input  logic                 down_2_in_tvalid,
    output logic                 down_2_in_tready,
    input  logic                 down_2_in_tlast,
    input  logic                 down_2_in_tuser,
    output xfcp_pkg::xfcp_byte_t down_2_out_tdata,
    output logic                 down_2_out_tvalid,
    input  logic                 down_2_out_tready,
    output logic                 down_2_out_tlast,
    output logic                 down_2_out_tuser,

    input  xfcp_pkg::xfcp_byte_t down_3_in_tdata,
    input  logic                 down_3_in_tvalid,
    output logic                 down_3_in_tready,
    input  logic                 down_3_in_tlast,
    input  logic                 down_3_in_tuser,
    output xfcp_pkg::xfcp_byte_t down_3_out_tdata,
    output logic                 down_3_out_tvalid,
    input  logic                 down_3_out_tready,
    output logic                 down_3_out_tlast,
    output logic                 down_3_out_tuser
);

    xfcp_stream_if up_in_s ();
    xfcp_stream_if up_out_s ();
    xfcp_stream_if down_in_s [`XFCP_DOWN_PORTS] ();
    xfcp_stream_if down_out_s [`XFCP_DOWN_PORTS] ();

    // upstream in, toward the router
    assign up_in_s.tdata  = up_in_tdata;
    assign up_in_s.tvalid = up_in_tvalid;
    assign up_in_s.tlast  = up_in_tlast;
    assign up_in_s.tuser  = up_in_tuser;
    assign up_in_tready   = up_in_s.tready;

    // upstream out, from the merger
    assign up_out_tdata    = up_out_s.tdata;
    assign up_out_tvalid   = up_out_s.tvalid;
    assign up_out_tlast    = up_out_s.tlast;
    assign up_out_tuser    = up_out_s.tuser;
    assign up_out_s.tready = up_out_tready;

    assign down_in_s[0].tdata  = down_0_in_tdata;
    assign down_in_s[0].tvalid = down_0_in_tvalid;
    assign down_in_s[0].tlast  = down_0_in_tlast;
    assign down_in_s[0].tuser  = down_0_in_tuser;
    assign down_0_in_tready    = down_in_s[0].tready;
    assign down_0_out_tdata     = down_out_s[0].tdata;
    assign down_0_out_tvalid    = down_out_s[0].tvalid;
    assign down_0_out_tlast     = down_out_s[0].tlast;
    assign down_0_out_tuser     = down_out_s[0].tuser;
    assign down_out_s[0].tready = down_0_out_tready;

    assign down_in_s[1].tdata  = down_1_in_tdata;
    assign down_in_s[1].tvalid = down_1_in_tvalid;
    assign down_in_s[1].tlast  = down_1_in_tlast;
    assign down_in_s[1].tuser  = down_1_in_tuser;
    assign down_1_in_tready    = down_in_s[1].tready;
    assign down_1_out_tdata     = down_out_s[1].tdata;
    assign down_1_out_tvalid    = down_out_s[1].tvalid;
    assign down_1_out_tlast     = down_out_s[1].tlast;
    assign down_1_out_tuser     = down_out_s[1].tuser;
    assign down_out_s[1].tready = down_1_out_tready;

    assign down_in_s[2].tdata  = down_2_in_tdata;
    assign down_in_s[2].tvalid = down_2_in_tvalid;
    assign down_in_s[2].tlast  = down_2_in_tlast;
    assign down_in_s[2].tuser  = down_2_in_tuser;
    assign down_2_in_tready    = down_in_s[2].tready;
    assign down_2_out_tdata     = down_out_s[2].tdata;
    assign down_2_out_tvalid    = down_out_s[2].tvalid;
    assign down_2_out_tlast     = down_out_s[2].tlast;
    assign down_2_out_tuser     = down_out_s[2].tuser;
    assign down_out_s[2].tready = down_2_out_tready;

    assign down_in_s[3].tdata  = down_3_in_tdata;
    assign down_in_s[3].tvalid = down_3_in_tvalid;
    assign down_in_s[3].tlast  = down_3_in_tlast;
    assign down_in_s[3].tuser  = down_3_in_tuser;
    assign down_3_in_tready    = down_in_s[3].tready;
    assign down_3_out_tdata     = down_out_s[3].tdata;
    assign down_3_out_tvalid    = down_out_s[3].tvalid;
    assign down_3_out_tlast     = down_out_s[3].tlast;
    assign down_3_out_tuser     = down_out_s[3].tuser;
    assign down_out_s[3].tready = down_3_out_tready;

    xfcp_down_router u_router (
        .clk      (clk),
        .rst      (rst),
        .up_in    (up_in_s),
        .down_out (down_out_s)
    );

    xfcp_up_merger u_merger (
        .clk     (clk),
        .rst     (rst),
        .down_in (down_in_s),
        .up_out  (up_out_s)
    );

endmodule

/* design/xfcp_up_merger.sv */
`include "xfcp_defs.svh"

module xfcp_up_merger (
    input  logic          clk,
    input  logic          rst,
    xfcp_stream_if.snk    down_in [`XFCP_DOWN_PORTS],
    xfcp_stream_if.src    up_out
);

    xfcp_pkg::up_state_t  state_reg;
    xfcp_pkg::up_state_t  state_next;

    xfcp_pkg::xfcp_byte_t in_data [`XFCP_DOWN_PORTS];
    xfcp_pkg::port_mask_t in_valid;
    xfcp_pkg::port_mask_t in_last;
    xfcp_pkg::port_mask_t in_user;
    xfcp_pkg::port_mask_t in_ready;

    xfcp_pkg::port_mask_t grant;
    logic                 grant_valid;
    xfcp_pkg::port_sel_t  grant_idx;
    logic                 done;

    xfcp_stream_if out_int ();

    for (genvar i = 0; i < `XFCP_DOWN_PORTS; i++) begin : g_port
        assign in_data[i]        = down_in[i].tdata;
        assign in_valid[i]       = down_in[i].tvalid;
        assign in_last[i]        = down_in[i].tlast;
        assign in_user[i]        = down_in[i].tuser;
        assign down_in[i].tready = in_ready[i];
    end

    xfcp_rr_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .request     (in_valid),
        .done        (done),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    // only the granted port sees ready, and only while its payload flows
    assign in_ready = grant & {`XFCP_DOWN_PORTS{out_int.tready
                                                && state_reg == xfcp_pkg::UP_TRANSFER}};

    always_comb begin
        state_next     = state_reg;
        done           = 1'b0;
        out_int.tdata  = in_data[grant_idx];
        out_int.tvalid = 1'b0;
        out_int.tlast  = in_last[grant_idx];
        out_int.tuser  = in_user[grant_idx];

        case (state_reg)
            xfcp_pkg::UP_IDLE: begin
                if (grant_valid) begin
                    state_next = xfcp_pkg::UP_HEADER;
                end
            end
            xfcp_pkg::UP_HEADER: begin
                // source port number goes out first
                out_int.tdata  = xfcp_pkg::xfcp_byte_t'(grant_idx);
                out_int.tvalid = 1'b1;
                out_int.tlast  = 1'b0;
                out_int.tuser  = 1'b0;
                if (out_int.tready) begin
                    state_next = xfcp_pkg::UP_TRANSFER;
                end
            end
            xfcp_pkg::UP_TRANSFER: begin
                out_int.tvalid = in_valid[grant_idx];
                if (in_valid[grant_idx] && out_int.tready && in_last[grant_idx]) begin
                    done       = 1'b1;
                    state_next = xfcp_pkg::UP_IDLE;
                end
            end
            default: begin
                state_next = xfcp_pkg::UP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= xfcp_pkg::UP_IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    xfcp_skid_buf u_skid (
        .clk   (clk),
        .rst   (rst),
        .in_s  (out_int),
        .out_s (up_out)
    );

endmodule

/* include/xfcp_defs.svh */
`ifndef XFCP_DEFS_SVH
`define XFCP_DEFS_SVH

// width of one stream beat
`define XFCP_DATA_W 8

// downstream ports on the switch
`define XFCP_DOWN_PORTS 4

// bits to index one downstream port
`define XFCP_SEL_W 2

`endif

/* run_sim.sh */
#!/bin/sh
# compile and run the xfcp switch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module xfcp_switch_tb \
    -Mdir obj_dir -o sim_xfcp_switch

./obj_dir/sim_xfcp_switch > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

/* sim.f */
+incdir+include
design/xfcp_pkg.sv
design/xfcp_stream_if.sv
design/xfcp_skid_buf.sv
design/xfcp_down_router.sv
design/xfcp_rr_arbiter.sv
design/xfcp_up_merger.sv
design/xfcp_switch.sv
tb/xfcp_switch_asserts.sv
tb/xfcp_switch_tb.sv

/* tb/switch_tests.txt */
# columns: type port n_stim stim_beats n_exp expected_beats
# beat is hex tuser<<9 | tlast<<8 | tdata, port is hex
# down and drop drive up_in, up drives down_<port>, arb port is a mask
# routing, header byte stripped
down 0 4 000 011 022 133 3 011 022 133
down 1 4 001 0a0 0b1 35c 3 0a0 0b1 35c
down 2 2 002 1ee 1 1ee
down 3 5 003 001 002 003 104 4 001 002 003 104
# out of range headers are swallowed
drop 0 3 004 055 166 0
drop 0 2 0fe 1aa 0
drop 0 4 0ff 010 020 330 0
drop 0 1 105 0
down 2 3 002 0c3 1c4 2 0c3 1c4
# arbitration from reset starts at port 0
arb f 7 0a0 1a1 1b0 0c0 0c1 1c2 3d0 11 000 0a0 1a1 001 1b0 002 0c0 0c1 1c2 003 3d0
# single upstream packets, prefix byte is the port number
up 2 3 0e0 0e1 1e2 4 002 0e0 0e1 1e2
up 0 2 071 372 3 000 071 372
# pointer now at port 1
arb 5 3 150 060 161 5 002 060 161 000 150
arb f 7 1f0 0f1 1f2 3f3 0f4 0f5 1f6 11 001 0f1 1f2 002 3f3 003 0f4 0f5 1f6 000 1f0

/* tb/xfcp_switch_asserts.sv */
`include "xfcp_defs.svh"

module xfcp_switch_asserts (
    input logic                          clk,
    input logic                          rst,
    // down ports in the low indexes, upstream port on top
    input logic [`XFCP_DOWN_PORTS:0]      out_valid,
    input logic [`XFCP_DOWN_PORTS:0]      out_ready,
    input logic [10*`XFCP_DOWN_PORTS+9:0] out_beat
);
    timeunit 1ns;
    timeprecision 1ps;

    for (genvar i = 0; i <= `XFCP_DOWN_PORTS; i++) begin : g_out
        stall_hold: assert property (@(posedge clk) disable iff (rst)
            out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(out_beat[i*10 +: 10]))
            else $error("output %0d changed while stalled", i);
    end

    // router never has two ports busy
    one_down_port: assert property (@(posedge clk) disable iff (rst)
        $onehot0(out_valid[`XFCP_DOWN_PORTS-1:0]))
        else $error("more than one down port valid");

    quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> out_valid == '0)
        else $error("tvalid output high during reset");

endmodule

bind xfcp_switch xfcp_switch_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .out_valid ({up_out_tvalid, down_3_out_tvalid, down_2_out_tvalid,
                 down_1_out_tvalid, down_0_out_tvalid}),
    .out_ready ({up_out_tready, down_3_out_tready, down_2_out_tready,
                 down_1_out_tready, down_0_out_tready}),
    .out_beat  ({up_out_tuser, up_out_tlast, up_out_tdata,
                 down_3_out_tuser, down_3_out_tlast, down_3_out_tdata,
                 down_2_out_tuser, down_2_out_tlast, down_2_out_tdata,
                 down_1_out_tuser, down_1_out_tlast, down_1_out_tdata,
                 down_0_out_tuser, down_0_out_tlast, down_0_out_tdata})
);

/* tb/xfcp_switch_tb.sv */
`include "xfcp_defs.svh"

module xfcp_switch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_STREAMS   = `XFCP_DOWN_PORTS + 1;
    localparam int UP_IDX        = `XFCP_DOWN_PORTS;
    localparam int WAIT_LIMIT    = 2000;
    localparam int SETTLE_CYCLES = 20;

    logic clk;
    logic rst;

    // index 0 to 3 are the down ports, the last index is the upstream port
    xfcp_pkg::xfcp_byte_t   in_tdata [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] in_tvalid;
    logic [NUM_STREAMS-1:0] in_tready;
    logic [NUM_STREAMS-1:0] in_tlast;
    logic [NUM_STREAMS-1:0] in_tuser;
    xfcp_pkg::xfcp_byte_t   out_tdata [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] out_tvalid;
    logic [NUM_STREAMS-1:0] out_tready;
    logic [NUM_STREAMS-1:0] out_tlast;
    logic [NUM_STREAMS-1:0] out_tuser;
    logic [NUM_STREAMS-1:0] accepted;

    // beats are {tuser, tlast, tdata}
    logic [9:0] tx_q [NUM_STREAMS][$];
    logic [9:0] rx_q [NUM_STREAMS][$];
    logic [9:0] want_q [NUM_STREAMS][$];
    logic [9:0] stim_q [$];
    logic [9:0] exp_q [$];

    int errors;
    int test_errors;
    int tests;
    int failed_tests;

    xfcp_switch dut (
        .clk (clk),
        .rst (rst),
        .up_in_tdata (in_tdata[4]), .up_in_tvalid (in_tvalid[4]), .up_in_tready (in_tready[4]),
        .up_in_tlast (in_tlast[4]), .up_in_tuser (in_tuser[4]),
        .up_out_tdata (out_tdata[4]), .up_out_tvalid (out_tvalid[4]),
        .up_out_tready (out_tready[4]), .up_out_tlast (out_tlast[4]), .up_out_tuser (out_tuser[4]),
        .down_0_in_tdata (in_tdata[0]), .down_0_in_tvalid (in_tvalid[0]),
        .down_0_in_tready (in_tready[0]), .down_0_in_tlast (in_tlast[0]),
        .down_0_in_tuser (in_tuser[0]),
        .down_0_out_tdata (out_tdata[0]), .down_0_out_tvalid (out_tvalid[0]),
        .down_0_out_tready (out_tready[0]), .down_0_out_tlast (out_tlast[0]),
        .down_0_out_tuser (out_tuser[0]),
        .down_1_in_tdata (in_tdata[1]), .down_1_in_tvalid (in_tvalid[1]),
        .down_1_in_tready (in_tready[1]), .down_1_in_tlast (in_tlast[1]),
        .down_1_in_tuser (in_tuser[1]),
        .down_1_out_tdata (out_tdata[1]), .down_1_out_tvalid (out_tvalid[1]),
        .down_1_out_tready (out_tready[1]), .down_1_out_tlast (out_tlast[1]),
        .down_1_out_tuser (out_tuser[1]),
        .down_2_in_tdata (in_tdata[2]), .down_2_in_tvalid (in_tvalid[2]),
        .down_2_in_tready (in_tready[2]), .down_2_in_tlast (in_tlast[2]),
        .down_2_in_tuser (in_tuser[2]),
        .down_2_out_tdata (out_tdata[2]), .down_2_out_tvalid (out_tvalid[2]),
        .down_2_out_tready (out_tready[2]), .down_2_out_tlast (out_tlast[2]),
        .down_2_out_tuser (out_tuser[2]),
        .down_3_in_tdata (in_tdata[3]), .down_3_in_tvalid (in_tvalid[3]),
        .down_3_in_tready (in_tready[3]), .down_3_in_tlast (in_tlast[3]),
        .down_3_in_tuser (in_tuser[3]),
        .down_3_out_tdata (out_tdata[3]), .down_3_out_tvalid (out_tvalid[3]),
        .down_3_out_tready (out_tready[3]), .down_3_out_tlast (out_tlast[3]),
        .down_3_out_tuser (out_tuser[3])
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure on every output, about three cycles in four ready
    always @(negedge clk) begin
        for (int s = 0; s < NUM_STREAMS; s++) begin
            out_tready[s] = ($urandom % 4) != 0;
        end
    end

    // output monitors and input acceptance
    always @(posedge clk) begin
        for (int s = 0; s < NUM_STREAMS; s++) begin
            if (!rst && out_tvalid[s] && out_tready[s]) begin
                rx_q[s].push_back({out_tuser[s], out_tlast[s], out_tdata[s]});
            end
        end
        accepted <= in_tvalid & in_tready;
    end

    function automatic string port_name(input int idx);
        if (idx == UP_IDX) begin
            return "up_out";
        end
        return $sformatf("down_%0d_out", idx);
    endfunction

    // n-th set bit of a port mask, the upstream index when there is none
    function automatic int nth_port(input int mask, input int n);
        int left;
        left = n;
        for (int p = 0; p < UP_IDX; p++) begin
            if (mask[p]) begin
                if (left == 0) begin
                    return p;
                end
                left--;
            end
        end
        return UP_IDX;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic run_drivers();
        int  cycles;
        bit  busy;
        cycles = 0;
        busy   = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int s = 0; s < NUM_STREAMS; s++) begin
                if (accepted[s] && tx_q[s].size() > 0) begin
                    void'(tx_q[s].pop_front());
                end
                if (tx_q[s].size() > 0) begin
                    {in_tuser[s], in_tlast[s], in_tdata[s]} = tx_q[s][0];
                    in_tvalid[s] = 1'b1;
                    busy         = 1'b1;
                end else begin
                    in_tvalid[s] = 1'b0;
                end
            end
            cycles++;
            if (busy && cycles > WAIT_LIMIT) begin
                $display("timeout: the switch stopped accepting stimulus beats");
                errors++;
                test_errors++;
                for (int s = 0; s < NUM_STREAMS; s++) begin
                    tx_q[s].delete();
                end
                in_tvalid = '0;
                busy      = 1'b0;
            end
        end
    endtask

    task automatic wait_for_beats(input int idx, input int count);
        int cycles;
        cycles = 0;
        while (rx_q[idx].size() < count) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: %s delivered only %0d of %0d beats",
                         port_name(idx), rx_q[idx].size(), count);
                errors++;
                test_errors++;
                break;
            end
        end
    endtask

    task automatic compare_port(input int idx);
        int         n_exp;
        logic [9:0] beat;
        logic [9:0] want;
        string      name;
        name  = port_name(idx);
        n_exp = want_q[idx].size();
        check_value({name, " beat count"}, rx_q[idx].size(), n_exp);
        for (int i = 0; i < n_exp && i < rx_q[idx].size(); i++) begin
            beat = rx_q[idx][i];
            want = want_q[idx][i];
            check_value({name, "_tdata"}, beat[7:0], want[7:0]);
            check_value({name, "_tlast"}, beat[8], want[8]);
            check_value({name, "_tuser"}, beat[9], want[9]);
        end
        rx_q[idx].delete();
        want_q[idx].delete();
    endtask

    task automatic run_test(input logic [63:0] kind, input int port);
        int pkt;
        int dst;
        test_errors = 0;
        pkt         = 0;
        if (kind == "down") begin
            tx_q[UP_IDX] = stim_q;
            want_q[port] = exp_q;
        end else if (kind == "split") begin
            // expected payloads belong to the ports of the mask in ascending order
            tx_q[UP_IDX] = stim_q;
            for (int i = 0; i < exp_q.size(); i++) begin
                dst = nth_port(port, pkt);
                if (dst < UP_IDX) begin
                    want_q[dst].push_back(exp_q[i]);
                end
                if (exp_q[i][8]) begin
                    pkt++;
                end
            end
        end else if (kind == "drop") begin
            tx_q[UP_IDX] = stim_q;
        end else if (kind == "up") begin
            tx_q[port]     = stim_q;
            want_q[UP_IDX] = exp_q;
        end else if (kind == "arb") begin
            // packets go to the ports of the mask in ascending order
            for (int i = 0; i < stim_q.size(); i++) begin
                dst = nth_port(port, pkt);
                if (dst < UP_IDX) begin
                    tx_q[dst].push_back(stim_q[i]);
                end
                if (stim_q[i][8]) begin
                    pkt++;
                end
            end
            want_q[UP_IDX] = exp_q;
        end else begin
            $display("unknown test type %0s in the vector file", kind);
            errors++;
            test_errors++;
        end
        run_drivers();
        for (int s = 0; s < NUM_STREAMS; s++) begin
            if (want_q[s].size() > 0) begin
                wait_for_beats(s, want_q[s].size());
            end
        end
        // extra time so that stray beats show up
        repeat (SETTLE_CYCLES) @(negedge clk);
        for (int s = 0; s < NUM_STREAMS; s++) begin
            compare_port(s);
        end
        tests++;
        if (test_errors > 0) begin
            failed_tests++;
        end
        $display("test %0d %0s %0h: %0s", tests, kind, port, test_errors == 0 ? "ok" : "mismatch");
    endtask

    initial begin
        int           fd;
        int           code;
        int           port;
        int           n_stim;
        int           n_exp;
        int           beat;
        logic [63:0]  kind;
        logic [959:0] rest;
        void'($urandom(32'h9a1c111b));
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        in_tvalid    = '0;
        in_tlast     = '0;
        in_tuser     = '0;
        out_tready   = '0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            in_tdata[s] = '0;
        end
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("tb/switch_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file tb/switch_tests.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %d", port, n_stim);
                    stim_q.delete();
                    exp_q.delete();
                    for (int i = 0; i < n_stim; i++) begin
                        code = $fscanf(fd, "%h", beat);
                        stim_q.push_back(beat[9:0]);
                    end
                    code = $fscanf(fd, "%d", n_exp);
                    for (int i = 0; i < n_exp; i++) begin
                        code = $fscanf(fd, "%h", beat);
                        exp_q.push_back(beat[9:0]);
                    end
                    run_test(kind, port);
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0 && tests > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
